/* source/dcache_lookup.sv */
`default_nettype none

module dcache_lookup (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  lsu_pkg::lsu_op_t            op_i,
    input  lsu_pkg::refill_t            refill_i,
    input  lsu_pkg::sb_entry_t          drain_i,
    output lsu_pkg::lsu_op_t            stage_op_o,
    output logic [lsu_pkg::WAY_NUM-1:0] way_hit_o,
    output logic [31:0]                 ram_word_o
);
    import lsu_pkg::*;

    lsu_op_t                 stage_op_q;
    sb_entry_t               wr_ent;
    sb_entry_t               hold_q;
    sb_entry_t               hold_d;
    logic                    drain_wr;
    logic [IDX_W+WOFS_W-1:0] rd_word;
    logic [IDX_W+WOFS_W-1:0] stage_word;
    logic [WAY_NUM-1:0]      conflict;
    logic [WAY_NUM-1:0]      conflict_q;
    logic [3:0]              wr_strb_q;
    logic [31:0]             wr_data_q;
    logic [TAG_W:0]          tag_rd [WAY_NUM];
    logic [31:0]             data_rd [WAY_NUM];
    logic [31:0]             way_word [WAY_NUM];

    assign rd_word    = {op_i.addr.f.idx, op_i.addr.f.wofs};
    assign stage_word = {stage_op_q.addr.f.idx, stage_op_q.addr.f.wofs};
    assign drain_wr   = drain_i.valid & drain_i.present;

    // port 1 source, refill first, then a held drain, then a fresh drain
    always_comb begin
        wr_ent = '0;
        hold_d = hold_q;
        if (refill_i.valid) begin
            wr_ent.valid   = 1'b1;
            wr_ent.waddr   = refill_i.addr.raw[31:2];
            wr_ent.strb    = 4'hf;
            wr_ent.data    = refill_i.word;
            wr_ent.way     = refill_i.way;
            wr_ent.present = 1'b1;
            if (!hold_q.valid) begin
                hold_d = drain_wr ? drain_i : '0;
            end
        end else if (hold_q.valid) begin
            wr_ent = hold_q;
            hold_d = drain_wr ? drain_i : '0;
        end else if (drain_wr) begin
            wr_ent = drain_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_op_q <= '0;
            conflict_q <= '0;
            hold_q     <= '0;
        end else begin
            stage_op_q <= flush_i ? '0 : op_i;
            conflict_q <= flush_i ? '0 : conflict;
            hold_q     <= hold_d;
        end
    end

    always_ff @(posedge clk) begin
        wr_strb_q <= wr_ent.strb;
        wr_data_q <= wr_ent.data;
    end

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        // same word written while it is read, the read port sees old data
        assign conflict[w] = op_i.valid & wr_ent.valid & (wr_ent.way == way_idx_t'(w))
                           & (wr_ent.waddr[IDX_W+WOFS_W-1:0] == rd_word);

        dpsram #(
            .DATA_W(TAG_W + 1),
            .DEPTH (SET_NUM),
            .STRB_W(1)
        ) u_tag_ram (
            .clk      (clk),
            .rd_en_i  (op_i.valid),
            .rd_addr_i(op_i.addr.f.idx),
            .rd_data_o(tag_rd[w]),
            .wr_en_i  (refill_i.valid && refill_i.way == way_idx_t'(w)),
            .wr_addr_i(refill_i.addr.f.idx),
            .wr_strb_i(1'b1),
            .wr_data_i({1'b1, refill_i.addr.f.tag})
        );

        dpsram #(
            .DATA_W(32),
            .DEPTH (SET_NUM * LINE_WORDS),
            .STRB_W(4)
        ) u_data_ram (
            .clk      (clk),
            .rd_en_i  (op_i.valid),
            .rd_addr_i(rd_word),
            .rd_data_o(data_rd[w]),
            .wr_en_i  (wr_ent.valid && wr_ent.way == way_idx_t'(w)),
            .wr_addr_i(wr_ent.waddr[IDX_W+WOFS_W-1:0]),
            .wr_strb_i(wr_ent.strb),
            .wr_data_i(wr_ent.data)
        );

        assign way_hit_o[w] = stage_op_q.valid & tag_rd[w][TAG_W]
                            & (tag_rd[w][TAG_W-1:0] == stage_op_q.addr.f.tag);

        // patch in bytes written at the read edge and bytes still in hold
        always_comb begin
            way_word[w] = data_rd[w];
            for (int b = 0; b < 4; b++) begin
                if (conflict_q[w] && wr_strb_q[b]) begin
                    way_word[w][8*b +: 8] = wr_data_q[8*b +: 8];
                end
                if (hold_q.valid && hold_q.way == way_idx_t'(w) && hold_q.strb[b]
                        && hold_q.waddr[IDX_W+WOFS_W-1:0] == stage_word) begin
                    way_word[w][8*b +: 8] = hold_q.data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        ram_word_o = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (way_hit_o[w]) begin
                ram_word_o = way_word[w];
            end
        end
    end

    assign stage_op_o = stage_op_q;

    a_one_way: assert property (@(posedge clk) disable iff (!rst_n_i)
        stage_op_q.valid |-> $onehot0(way_hit_o))
        else $error("line present in more than one way");

endmodule

`default_nettype wire

/* source/dpsram.sv */
`default_nettype none

module dpsram #(
    parameter int unsigned DATA_W = 32,
    parameter int unsigned DEPTH  = 64,
    parameter int unsigned STRB_W = 4,
    parameter int unsigned ADDR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    // port 0, read only
    input  logic              rd_en_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output logic [DATA_W-1:0] rd_data_o,
    // port 1, write only, lane strobes
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic [STRB_W-1:0] wr_strb_i,
    input  logic [DATA_W-1:0] wr_data_i
);

    // cleared at start so every tag begins invalid
    logic [DATA_W-1:0] mem [DEPTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int l = 0; l < STRB_W; l++) begin
                if (wr_strb_i[l]) begin
                    mem[wr_addr_i][l*(DATA_W/STRB_W) +: (DATA_W/STRB_W)] <=
                        wr_data_i[l*(DATA_W/STRB_W) +: (DATA_W/STRB_W)];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/load_result.sv */
`default_nettype none

module load_result (
    input  lsu_pkg::lsu_op_t            stage_op_i,
    input  logic [lsu_pkg::WAY_NUM-1:0] way_hit_i,
    input  logic [31:0]                 ram_word_i,
    input  lsu_pkg::sb_fwd_t            fwd_i,
    output lsu_pkg::lsu_resp_t          resp_o
);
    import lsu_pkg::*;

    logic [31:0] merged;
    logic [31:0] shifted;
    logic [31:0] ext;
    logic        fwd_full;
    logic        hit;

    // pending stores override the SRAM copy
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = fwd_i.hit[b] ? fwd_i.data[8*b +: 8] : ram_word_i[8*b +: 8];
        end
    end

    assign fwd_full = (stage_op_i.mask & fwd_i.hit) == stage_op_i.mask;
    assign hit      = (|way_hit_i) | fwd_full;

    assign shifted = merged >> {stage_op_i.addr.f.bofs, 3'b000};

    always_comb begin
        case (stage_op_i.size)
            MEM_BYTE: ext = {{24{stage_op_i.sign & shifted[7]}}, shifted[7:0]};
            MEM_HALF: ext = {{16{stage_op_i.sign & shifted[15]}}, shifted[15:0]};
            default:  ext = merged;
        endcase
    end

    always_comb begin
        resp_o.valid = stage_op_i.valid & !stage_op_i.store;
        resp_o.hit   = hit;
        // a miss returns zero
        resp_o.data  = hit ? ext : '0;
    end

endmodule

`default_nettype wire

/* source/lsu_decode.sv */
`default_nettype none

module lsu_decode (
    input  lsu_pkg::lsu_req_t req_i,
    input  logic              req_valid_i,
    input  logic              accept_i,
    output lsu_pkg::lsu_op_t  op_o
);
    import lsu_pkg::*;

    logic [3:0] mask;

    // byte lanes touched by the access
    always_comb begin
        case (req_i.size)
            MEM_BYTE: mask = 4'b0001 << req_i.addr.f.bofs;
            MEM_HALF: mask = req_i.addr.f.bofs[1] ? 4'b1100 : 4'b0011;
            default:  mask = 4'b1111;
        endcase
    end

    always_comb begin
        op_o.valid = req_valid_i & accept_i;
        op_o.store = req_i.store;
        op_o.addr  = req_i.addr;
        op_o.mask  = mask;
        op_o.size  = req_i.size;
        op_o.sign  = req_i.sign;
        op_o.wdata = req_i.wdata;
    end

    // the core only hands over naturally aligned accesses
    always_comb begin
        if (op_o.valid) begin
            a_half_align: assert final (op_o.size != MEM_HALF || !op_o.addr.f.bofs[0])
                else $error("misaligned half access at %h", op_o.addr.raw);
            a_word_align: assert final (op_o.size != MEM_WORD || op_o.addr.f.bofs == 2'b00)
                else $error("misaligned word access at %h", op_o.addr.raw);
        end
    end

endmodule

`default_nettype wire

/* source/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // cache geometry
    localparam int unsigned WAY_NUM    = 2;
    localparam int unsigned SET_NUM    = 16;
    localparam int unsigned LINE_WORDS = 4;
    localparam int unsigned SB_SIZE    = 4;

    // address split, tag | index | word | byte
    localparam int unsigned TAG_W  = 24;
    localparam int unsigned IDX_W  = 4;
    localparam int unsigned WOFS_W = 2;

    typedef logic [$clog2(WAY_NUM)-1:0] way_idx_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [IDX_W-1:0]  idx;
        logic [WOFS_W-1:0] wofs;
        logic [1:0]        bofs;
    } lsu_addr_fields_t;

    // raw form for store-buffer matching, field form for SRAM indexing
    typedef union packed {
        logic [31:0]      raw;
        lsu_addr_fields_t f;
    } lsu_addr_u;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // write data already sits in its byte lanes
    typedef struct packed {
        logic      store;
        lsu_addr_u addr;
        mem_size_e size;
        logic      sign;
        logic [31:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        logic        valid;
        logic        store;
        lsu_addr_u   addr;
        logic [3:0]  mask;
        mem_size_e   size;
        logic        sign;
        logic [31:0] wdata;
    } lsu_op_t;

    typedef struct packed {
        logic        valid;
        logic [29:0] waddr;
        logic [3:0]  strb;
        logic [31:0] data;
        way_idx_t    way;
        // line was resident when the store looked it up
        logic        present;
    } sb_entry_t;

    typedef struct packed {
        logic [3:0]  hit;
        logic [31:0] data;
    } sb_fwd_t;

    typedef struct packed {
        logic        valid;
        way_idx_t    way;
        lsu_addr_u   addr;
        logic [31:0] word;
    } refill_t;

    typedef struct packed {
        logic        valid;
        logic        hit;
        logic [31:0] data;
    } lsu_resp_t;

endpackage

`default_nettype wire

/* source/lsu_top.sv */
`default_nettype none

module lsu_top (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               commit_i,
    input  logic               req_valid_i,
    input  lsu_pkg::lsu_req_t  req_i,
    input  lsu_pkg::refill_t   refill_i,
    output logic               req_ready_o,
    output lsu_pkg::lsu_resp_t resp_o
);
    import lsu_pkg::*;

    logic               ready_en_q;
    logic               sb_full;
    lsu_op_t            op;
    lsu_op_t            stage_op;
    logic [WAY_NUM-1:0] way_hit;
    logic [31:0]        ram_word;
    sb_fwd_t            fwd;
    sb_entry_t          drain;
    way_idx_t           push_way;

    // ready comes up one cycle after reset is released
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_en_q <= 1'b0;
        end else begin
            ready_en_q <= 1'b1;
        end
    end

    assign req_ready_o = ready_en_q & !sb_full & !flush_i;

    always_comb begin
        push_way = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (way_hit[w]) begin
                push_way = way_idx_t'(w);
            end
        end
    end

    lsu_decode u_decode (
        .req_i      (req_i),
        .req_valid_i(req_valid_i),
        .accept_i   (req_ready_o),
        .op_o       (op)
    );

    dcache_lookup u_lookup (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .op_i      (op),
        .refill_i  (refill_i),
        .drain_i   (drain),
        .stage_op_o(stage_op),
        .way_hit_o (way_hit),
        .ram_word_o(ram_word)
    );

    store_buffer u_sb (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .commit_i      (commit_i),
        .push_i        (stage_op),
        .push_hit_way_i(push_way),
        .push_present_i(|way_hit),
        .fwd_addr_i    (stage_op.addr),
        .fwd_o         (fwd),
        .drain_o       (drain),
        .full_o        (sb_full)
    );

    load_result u_result (
        .stage_op_i(stage_op),
        .way_hit_i (way_hit),
        .ram_word_i(ram_word),
        .fwd_i     (fwd),
        .resp_o    (resp_o)
    );

endmodule

`default_nettype wire

/* source/store_buffer.sv */
`default_nettype none

module store_buffer (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               flush_i,
    input  logic               commit_i,
    input  lsu_pkg::lsu_op_t   push_i,
    input  lsu_pkg::way_idx_t  push_hit_way_i,
    input  logic               push_present_i,
    input  lsu_pkg::lsu_addr_u fwd_addr_i,
    output lsu_pkg::sb_fwd_t   fwd_o,
    output lsu_pkg::sb_entry_t drain_o,
    output logic               full_o
);
    import lsu_pkg::*;

    sb_entry_t                  entry_q [SB_SIZE];
    sb_entry_t                  new_entry;
    logic [$clog2(SB_SIZE)-1:0] head_q;
    logic [$clog2(SB_SIZE)-1:0] tail_q;
    logic [$clog2(SB_SIZE):0]   count_q;
    logic                       push;
    logic                       pop;

    assign push = push_i.valid & push_i.store;
    assign pop  = commit_i & (count_q != '0);

    // the store sitting in the stage still needs a slot
    assign full_o = (count_q == SB_SIZE) || ((count_q == SB_SIZE - 1) && push);

    always_comb begin
        new_entry.valid   = 1'b1;
        new_entry.waddr   = push_i.addr.raw[31:2];
        new_entry.strb    = push_i.mask;
        new_entry.data    = push_i.wdata;
        new_entry.way     = push_hit_way_i;
        new_entry.present = push_present_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < SB_SIZE; i++) begin
                entry_q[i] <= '0;
            end
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < SB_SIZE; i++) begin
                entry_q[i].valid <= 1'b0;
            end
        end else begin
            if (push) begin
                entry_q[tail_q] <= new_entry;
                tail_q          <= tail_q + 1'b1;
            end
            if (pop) begin
                entry_q[head_q].valid <= 1'b0;
                head_q                <= head_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // newest entry first, a byte is taken once
    always_comb begin
        logic [$clog2(SB_SIZE)-1:0] idx;
        fwd_o = '0;
        for (int k = 1; k <= SB_SIZE; k++) begin
            idx = tail_q - k[$clog2(SB_SIZE)-1:0];
            if (entry_q[idx].valid && entry_q[idx].waddr == fwd_addr_i.raw[31:2]) begin
                for (int b = 0; b < 4; b++) begin
                    if (entry_q[idx].strb[b] && !fwd_o.hit[b]) begin
                        fwd_o.hit[b]          = 1'b1;
                        fwd_o.data[8*b +: 8] = entry_q[idx].data[8*b +: 8];
                    end
                end
            end
        end
    end

    always_comb begin
        drain_o       = entry_q[head_q];
        drain_o.valid = entry_q[head_q].valid & commit_i;
    end

    a_commit_nonempty: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_i |-> count_q != '0)
        else $error("commit with an empty store buffer");

    a_push_room: assert property (@(posedge clk) disable iff (!rst_n_i)
        push |-> count_q != SB_SIZE)
        else $error("store pushed into a full store buffer");

endmodule

`default_nettype wire

/* tb.f */
source/lsu_pkg.sv
source/dpsram.sv
source/lsu_decode.sv
source/store_buffer.sv
source/dcache_lookup.sv
source/load_result.sv
source/lsu_top.sv
tests/tb_clock.sv
tests/lsu_tb.sv

/* tests/lsu_cases.txt */
# kind addr way size sign data hit expdata, size 0 byte 1 half 2 word
# rstore data comes from urandom, for rload data is the SRAM word and hit the line present flag
refill 00001040 0 2 0 f1e283a4 0 00000000
refill 00001044 0 2 0 12345678 0 00000000
refill 00002044 1 2 0 0badf00d 0 00000000
load   00001040 0 2 0 00000000 1 f1e283a4
load   00001040 0 0 1 00000000 1 ffffffa4
load   00001041 0 0 0 00000000 1 00000083
load   00001042 0 1 1 00000000 1 fffff1e2
load   00001040 0 1 0 00000000 1 000083a4
load   00002044 0 2 0 00000000 1 0badf00d
load   00003080 0 2 0 00000000 0 00000000
store  00005000 0 2 0 cafe0001 0 00000000
load   00005000 0 2 0 00000000 1 cafe0001
store  00001045 0 0 0 0000ee00 0 00000000
load   00001044 0 2 0 00000000 1 1234ee78
commit 00000000 0 0 0 00000000 0 00000000
commit 00000000 0 0 0 00000000 0 00000000
load   00001044 0 2 0 00000000 1 1234ee78
load   00005000 0 2 0 00000000 0 00000000
rstore 00006000 0 0 0 00000000 0 00000000
rstore 00006002 0 1 0 00000000 0 00000000
rload  00006000 0 2 0 00000000 0 00000000
rstore 00006001 0 0 0 00000000 0 00000000
rload  00006000 0 2 0 00000000 0 00000000
rload  00006002 0 1 1 00000000 0 00000000
rstore 00001040 0 1 0 00000000 0 00000000
idle   00000000 0 0 0 00000000 0 00000000
commit 00000000 0 0 0 00000000 0 00000000
idle   00000000 0 0 0 00000000 0 00000000
rload  00006000 0 2 0 00000000 0 00000000
rload  00001040 0 2 0 f1e283a4 1 00000000
flush  00000000 0 0 0 00000000 0 00000000
rload  00001040 0 2 0 f1e283a4 1 00000000

/* tests/lsu_tb.sv */
`default_nettype none

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        OP_REFILL, OP_LOAD, OP_STORE, OP_RSTORE, OP_RLOAD, OP_COMMIT, OP_FLUSH, OP_IDLE
    } op_kind_e;

    typedef struct packed {
        op_kind_e    kind;
        logic [31:0] addr;
        logic        way;
        logic [1:0]  size;
        logic        sign;
        logic [31:0] data;
        logic        hit;
        logic [31:0] exp_data;
    } case_t;

    // expected store buffer contents, oldest first
    typedef struct packed {
        logic [29:0] waddr;
        logic [3:0]  strb;
        logic [31:0] data;
    } pending_t;

    logic      clk;
    logic      rst_n;
    logic      flush;
    logic      commit;
    logic      req_valid;
    logic      req_ready;
    lsu_req_t  req;
    refill_t   refill;
    lsu_resp_t resp;
    case_t     cases [$];
    pending_t  pending [$];
    int        errors;
    int        mismatches;
    bit        cases_loaded;

    tb_clock #(.PERIOD_NS(20)) u_clock (.clk_o(clk));

    lsu_top u_dut (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .flush_i    (flush),
        .commit_i   (commit),
        .req_valid_i(req_valid),
        .req_i      (req),
        .refill_i   (refill),
        .req_ready_o(req_ready),
        .resp_o     (resp)
    );

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    // lanes covered by an aligned access of 1, 2 or 4 bytes
    function automatic logic [3:0] byte_mask(input logic [1:0] ofs, input logic [1:0] size);
        logic [3:0] mask;
        int         len;
        int         first;
        len   = 1 << size;
        first = ofs & ~(len - 1);
        for (int b = 0; b < 4; b++) begin
            mask[b] = (b >= first) && (b < first + len);
        end
        return mask;
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] word, input logic [1:0] ofs,
                                                input logic [1:0] size, input logic sign);
        logic [31:0] value;
        logic [31:0] keep;
        int          bits;
        bits  = 8 << size;
        value = word >> (8 * ofs);
        if (bits < 32) begin
            keep  = (32'd1 << bits) - 1;
            value = value & keep;
            if (sign && value[bits-1]) begin
                value = value | ~keep;
            end
        end
        return value;
    endfunction

    // newest pending store wins per byte, the SRAM word fills the rest
    task automatic predict_load(input case_t c, output logic exp_hit, output logic [31:0] exp_data);
        logic [31:0] merged;
        logic [3:0]  covered;
        logic [3:0]  mask;
        merged  = c.hit ? c.data : 32'h0;
        covered = '0;
        mask    = byte_mask(c.addr[1:0], c.size);
        for (int i = pending.size() - 1; i >= 0; i--) begin
            if (pending[i].waddr == c.addr[31:2]) begin
                for (int b = 0; b < 4; b++) begin
                    if (pending[i].strb[b] && !covered[b]) begin
                        covered[b]       = 1'b1;
                        merged[8*b +: 8] = pending[i].data[8*b +: 8];
                    end
                end
            end
        end
        exp_hit  = c.hit || ((mask & covered) == mask);
        exp_data = exp_hit ? extend_load(merged, c.addr[1:0], c.size, c.sign) : 32'h0;
    endtask

    task automatic update_model(input case_t c, input logic [31:0] wdata);
        pending_t p;
        if (c.kind == OP_STORE || c.kind == OP_RSTORE) begin
            p.waddr = c.addr[31:2];
            p.strb  = byte_mask(c.addr[1:0], c.size);
            p.data  = wdata;
            pending.push_back(p);
        end else if (c.kind == OP_COMMIT && pending.size() > 0) begin
            void'(pending.pop_front());
        end else if (c.kind == OP_FLUSH) begin
            pending.delete();
        end
    endtask

    task automatic set_idle();
        req_valid = 1'b0;
        req       = '0;
        refill    = '0;
        commit    = 1'b0;
        flush     = 1'b0;
    endtask

    task automatic read_cases();
        int          fd;
        int          n;
        int          way;
        int          size;
        int          sign;
        int          hit;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_data;
        string       kind_s;
        string       rest;
        bit          known;
        case_t       c;
        fd = $fopen("tests/lsu_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file tests/lsu_cases.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", kind_s);
            if (n != 1) begin
                break;
            end
            if (kind_s[0] == "#") begin
                void'($fgets(rest, fd));
                continue;
            end
            n = $fscanf(fd, "%h %d %d %d %h %d %h", addr, way, size, sign, data, hit, exp_data);
            if (n != 7) begin
                $display("cases file line for %s has missing fields", kind_s);
                errors++;
                break;
            end
            known = 1'b1;
            case (kind_s)
                "refill": c.kind = OP_REFILL;
                "load":   c.kind = OP_LOAD;
                "store":  c.kind = OP_STORE;
                "rstore": c.kind = OP_RSTORE;
                "rload":  c.kind = OP_RLOAD;
                "commit": c.kind = OP_COMMIT;
                "flush":  c.kind = OP_FLUSH;
                "idle":   c.kind = OP_IDLE;
                default: begin
                    $display("unknown operation %s in the cases file", kind_s);
                    errors++;
                    known = 1'b0;
                end
            endcase
            c.addr     = addr;
            c.way      = way[0];
            c.size     = size[1:0];
            c.sign     = sign[0];
            c.data     = data;
            c.hit      = hit[0];
            c.exp_data = exp_data;
            if (known) begin
                cases.push_back(c);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input case_t c);
        logic        exp_ready;
        logic        exp_hit;
        logic [31:0] exp_data;
        logic [31:0] wdata;
        logic        is_load;
        logic        is_store;
        is_load   = (c.kind == OP_LOAD) || (c.kind == OP_RLOAD);
        is_store  = (c.kind == OP_STORE) || (c.kind == OP_RSTORE);
        // buffer full or flush refuses every request
        exp_ready = (c.kind != OP_FLUSH) && (pending.size() < SB_SIZE);
        exp_hit   = c.hit;
        exp_data  = c.exp_data;
        if (c.kind == OP_RLOAD) begin
            predict_load(c, exp_hit, exp_data);
        end
        wdata = (c.kind == OP_RSTORE) ? $urandom : c.data;
        @(negedge clk);
        case (c.kind)
            OP_REFILL: begin
                refill.valid    = 1'b1;
                refill.way      = way_idx_t'(c.way);
                refill.addr.raw = c.addr;
                refill.word     = c.data;
            end
            OP_COMMIT: commit = 1'b1;
            OP_FLUSH:  flush = 1'b1;
            default:   ;
        endcase
        if (is_load || is_store) begin
            req_valid    = 1'b1;
            req.store    = is_store;
            req.addr.raw = c.addr;
            req.size     = mem_size_e'(c.size);
            req.sign     = c.sign;
            req.wdata    = wdata;
        end
        #1;
        check_eq("req_ready_o", req_ready, exp_ready);
        while ((is_load || is_store) && !req_ready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        if (is_load) begin
            check_eq("resp_o.valid", resp.valid, 1'b1);
            check_eq("resp_o.hit", resp.hit, exp_hit);
            check_eq("resp_o.data", resp.data, exp_data);
        end else begin
            check_eq("resp_o.valid", resp.valid, 1'b0);
        end
        update_model(c, wdata);
        set_idle();
    endtask

    initial begin
        void'($urandom(84));
        errors     = 0;
        mismatches = 0;
        rst_n      = 1'b0;
        set_idle();
        read_cases();
        cases_loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_eq("req_ready_o", req_ready, 1'b0);
        check_eq("resp_o.valid", resp.valid, 1'b0);
        rst_n = 1'b1;
        foreach (cases[i]) begin
            run_case(cases[i]);
        end
        repeat (2) @(negedge clk);
        $display("closing counts: %0d errors, %0d mismatches", errors, mismatches);
        if (errors == 0 && mismatches == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // budget of ten cycles per case plus slack
    initial begin
        wait (cases_loaded);
        repeat (cases.size() * 10 + 100) @(posedge clk);
        $display("timeout, %0d cases did not complete within the cycle budget", cases.size());
        errors++;
        $display("closing counts: %0d errors, %0d mismatches", errors, mismatches);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int unsigned PERIOD_NS = 20
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire
